//--- logic/lbm_pkg.sv
`default_nettype none

package lbm_pkg;

  // d2q9 lattice
  localparam int q_dirs = 9;

  // lattice velocities in direction order
  // 0 rest, 1 east, 2 north, 3 west, 4 south, 5..8 diagonals
  localparam int dir_cx [q_dirs] = '{0, 1, 0, -1, 0, 1, -1, -1, 1};
  localparam int dir_cy [q_dirs] = '{0, 0, 1, 0, -1, 1, 1, -1, -1};

  // moment controller
  typedef enum logic [1:0] {
    st_idle,
    st_sum,
    st_div,
    st_ack
  } ctrl_state_e;

endpackage

`default_nettype wire

//--- logic/moment_sum.sv
`default_nettype none

module moment_sum import lbm_pkg::*; #(
  parameter int DATA_WIDTH = 32
) (
  input  logic                           clock_50,
  input  logic                           arst_n,
  input  logic                           load,
  input  logic [q_dirs*DATA_WIDTH-1:0]   fin,
  output logic signed [DATA_WIDTH-1:0]   rho_sum,
  output logic signed [DATA_WIDTH-1:0]   px_sum,
  output logic signed [DATA_WIDTH-1:0]   py_sum
);

  logic signed [DATA_WIDTH-1:0] rho_next;
  logic signed [DATA_WIDTH-1:0] px_next;
  logic signed [DATA_WIDTH-1:0] py_next;

  // velocities are only -1, 0 or +1 so no multiplier is needed
  always_comb begin
    logic signed [DATA_WIDTH-1:0] val;
    rho_next = '0;
    px_next  = '0;
    py_next  = '0;
    val      = '0;
    for (int i = 0; i < q_dirs; i++) begin
      val      = fin[i*DATA_WIDTH +: DATA_WIDTH];
      rho_next = rho_next + val;
      if (dir_cx[i] > 0) begin
        px_next = px_next + val;
      end else if (dir_cx[i] < 0) begin
        px_next = px_next - val;
      end
      if (dir_cy[i] > 0) begin
        py_next = py_next + val;
      end else if (dir_cy[i] < 0) begin
        py_next = py_next - val;
      end
    end
  end

  // sums wrap at DATA_WIDTH
  always_ff @(posedge clock_50 or negedge arst_n) begin
    if (!arst_n) begin
      rho_sum <= '0;
      px_sum  <= '0;
      py_sum  <= '0;
    end else if (load) begin
      rho_sum <= rho_next;
      px_sum  <= px_next;
      py_sum  <= py_next;
    end
  end

endmodule

`default_nettype wire

//--- logic/fp_divider.sv
`default_nettype none

module fp_divider #(
  parameter int DATA_WIDTH = 32,
  parameter int FRAC_BITS  = 24
) (
  input  logic                         clock_50,
  input  logic                         arst_n,
  input  logic                         start,
  input  logic signed [DATA_WIDTH-1:0] dividend,
  input  logic signed [DATA_WIDTH-1:0] divisor,
  output logic                         done,
  output logic signed [DATA_WIDTH-1:0] quotient,
  output logic                         dbz,
  output logic                         ovf
);

  localparam int steps = DATA_WIDTH + FRAC_BITS;
  localparam int cnt_w = $clog2(steps + 1);

  // largest magnitudes for a positive and a negative result
  localparam logic [steps-1:0] pos_max = {{FRAC_BITS{1'b0}}, 1'b0, {(DATA_WIDTH-1){1'b1}}};
  localparam logic [steps-1:0] neg_max = {{FRAC_BITS{1'b0}}, 1'b1, {(DATA_WIDTH-1){1'b0}}};

  logic                  busy;
  logic [cnt_w-1:0]      cnt;
  logic [steps-1:0]      num;
  logic [DATA_WIDTH-1:0] den;
  logic [DATA_WIDTH:0]   rem;
  logic [steps-1:0]      quo;
  logic                  neg;
  logic                  zero_div;

  logic [DATA_WIDTH-1:0] dividend_mag;
  logic [DATA_WIDTH-1:0] divisor_mag;
  logic [DATA_WIDTH:0]   rem_shift;
  logic [DATA_WIDTH:0]   rem_trial;
  logic                  fits;
  logic                  too_big;
  logic [DATA_WIDTH-1:0] q_mag;
  logic [DATA_WIDTH-1:0] q_signed;

  // -min wraps to the correct unsigned magnitude
  assign dividend_mag = dividend[DATA_WIDTH-1] ? DATA_WIDTH'(-dividend) : dividend;
  assign divisor_mag  = divisor[DATA_WIDTH-1] ? DATA_WIDTH'(-divisor) : divisor;

  // one restoring step
  assign rem_shift = {rem[DATA_WIDTH-1:0], num[steps-1]};
  assign rem_trial = rem_shift - {1'b0, den};
  assign fits      = rem_shift >= {1'b0, den};

  // range check and sign after the last step
  assign too_big  = neg ? (quo > neg_max) : (quo > pos_max);
  assign q_mag    = quo[DATA_WIDTH-1:0];
  assign q_signed = neg ? -q_mag : q_mag;

  always_ff @(posedge clock_50 or negedge arst_n) begin
    if (!arst_n) begin
      busy     <= 1'b0;
      cnt      <= '0;
      done     <= 1'b0;
      quotient <= '0;
      dbz      <= 1'b0;
      ovf      <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy <= 1'b1;
        cnt  <= '0;
      end else if (busy) begin
        if (cnt == cnt_w'(steps)) begin
          busy <= 1'b0;
          done <= 1'b1;
          dbz  <= zero_div;
          ovf  <= !zero_div && too_big;
          if (zero_div || too_big) begin
            quotient <= '0;
          end else begin
            quotient <= q_signed;
          end
        end else begin
          cnt <= cnt + 1'b1;
        end
      end
    end
  end

  // datapath
  always_ff @(posedge clock_50) begin
    if (start) begin
      num      <= {dividend_mag, {FRAC_BITS{1'b0}}};
      den      <= divisor_mag;
      rem      <= '0;
      quo      <= '0;
      neg      <= dividend[DATA_WIDTH-1] ^ divisor[DATA_WIDTH-1];
      zero_div <= (divisor == '0);
    end else if (busy && cnt != cnt_w'(steps)) begin
      num <= {num[steps-2:0], 1'b0};
      quo <= {quo[steps-2:0], fits};
      rem <= fits ? rem_trial : rem_shift;
    end
  end

endmodule

`default_nettype wire

//--- logic/moment_ctrl.sv
`default_nettype none

module moment_ctrl import lbm_pkg::*; (
  input  logic clock_50,
  input  logic arst_n,
  input  logic req,
  input  logic div_done,
  output logic load,
  output logic div_start,
  output logic ack
);

  ctrl_state_e state;

  // outputs are registered alongside the state
  always_ff @(posedge clock_50 or negedge arst_n) begin
    if (!arst_n) begin
      state     <= st_idle;
      load      <= 1'b0;
      div_start <= 1'b0;
      ack       <= 1'b0;
    end else begin
      load      <= 1'b0;
      div_start <= 1'b0;
      case (state)
        st_idle: begin
          if (req) begin
            // capture the sums next cycle
            load  <= 1'b1;
            state <= st_sum;
          end
        end
        st_sum: begin
          div_start <= 1'b1;
          state     <= st_div;
        end
        st_div: begin
          // both dividers finish together
          if (div_done) begin
            ack   <= 1'b1;
            state <= st_ack;
          end
        end
        st_ack: begin
          if (!req) begin
            ack   <= 1'b0;
            state <= st_idle;
          end
        end
        default: begin
          ack   <= 1'b0;
          state <= st_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- logic/lbm_moments.sv
`default_nettype none

module lbm_moments import lbm_pkg::*; #(
  parameter int DATA_WIDTH = 32,
  parameter int FRAC_BITS  = 24
) (
  input  logic                          clock_50,
  input  logic                          arst_n,
  input  logic                          req,
  input  logic [q_dirs*DATA_WIDTH-1:0]  fin,
  output logic                          ack,
  output logic signed [DATA_WIDTH-1:0]  rho,
  output logic signed [DATA_WIDTH-1:0]  ux,
  output logic signed [DATA_WIDTH-1:0]  uy,
  output logic                          dbz,
  output logic                          ovf_x,
  output logic                          ovf_y
);

  logic                         load;
  logic                         div_start;
  logic                         div_done;
  logic signed [DATA_WIDTH-1:0] rho_sum;
  logic signed [DATA_WIDTH-1:0] px_sum;
  logic signed [DATA_WIDTH-1:0] py_sum;

  assign rho = rho_sum;

  moment_sum #(
    .DATA_WIDTH (DATA_WIDTH)
  ) i_sum (
    .clock_50 (clock_50),
    .arst_n   (arst_n),
    .load     (load),
    .fin      (fin),
    .rho_sum  (rho_sum),
    .px_sum   (px_sum),
    .py_sum   (py_sum)
  );

  // ux = px / rho
  fp_divider #(
    .DATA_WIDTH (DATA_WIDTH),
    .FRAC_BITS  (FRAC_BITS)
  ) div_ux (
    .clock_50 (clock_50),
    .arst_n   (arst_n),
    .start    (div_start),
    .dividend (px_sum),
    .divisor  (rho_sum),
    .done     (div_done),
    .quotient (ux),
    .dbz      (dbz),
    .ovf      (ovf_x)
  );

  // uy = py / rho with the same divisor and timing as div_ux
  fp_divider #(
    .DATA_WIDTH (DATA_WIDTH),
    .FRAC_BITS  (FRAC_BITS)
  ) div_uy (
    .clock_50 (clock_50),
    .arst_n   (arst_n),
    .start    (div_start),
    .dividend (py_sum),
    .divisor  (rho_sum),
    .done     (),
    .quotient (uy),
    .dbz      (),
    .ovf      (ovf_y)
  );

  moment_ctrl i_ctrl (
    .clock_50  (clock_50),
    .arst_n    (arst_n),
    .req       (req),
    .div_done  (div_done),
    .load      (load),
    .div_start (div_start),
    .ack       (ack)
  );

endmodule

`default_nettype wire

//--- dv/lbm_moments_checker.sv
`default_nettype none

module lbm_moments_checker (
  input logic clock_50,
  input logic arst_n,
  input logic req,
  input logic ack
);

  // ack only answers a pending request
  ack_needs_req: assert property (
    @(posedge clock_50) disable iff (!arst_n)
    $rose(ack) |-> $past(req)
  ) else $error("ack rose without a request");

  // results are held as long as the requester waits
  ack_held: assert property (
    @(posedge clock_50) disable iff (!arst_n)
    (ack && req) |=> ack
  ) else $error("ack dropped while req was still high");

  // first cycle out of reset
  ack_low_after_reset: assert property (
    @(posedge clock_50)
    $rose(arst_n) |-> !ack
  ) else $error("ack high right after reset release");

endmodule

bind lbm_moments lbm_moments_checker i_checker (
  .clock_50 (clock_50),
  .arst_n   (arst_n),
  .req      (req),
  .ack      (ack)
);

`default_nettype wire

//--- dv/lbm_moments_tb.sv
`default_nettype none

module lbm_moments_tb import lbm_pkg::*; ();

  localparam int DATA_WIDTH = 32;
  localparam int FRAC_BITS  = 24;

  localparam int reset_cycles = 8;
  localparam int latency      = DATA_WIDTH + FRAC_BITS + 4;
  localparam int n_random     = 200;
  localparam int n_symmetric  = 10;
  localparam int n_overflow   = 4;
  localparam int n_handshake  = 20;
  localparam int hold_max     = 15;
  localparam int n_trans      = n_random + 2 * n_symmetric + 1 + n_overflow + n_handshake;
  // latency, handshake overhead and longest hold for each transaction
  localparam int cycle_limit  = n_trans * (latency + 10 + hold_max) + reset_cycles + 200;
  localparam int unit_fp      = 1 << FRAC_BITS;

  logic                         clock_50 = 1'b0;
  logic                         arst_n;
  logic                         req;
  logic [q_dirs*DATA_WIDTH-1:0] fin;
  logic                         ack;
  logic signed [DATA_WIDTH-1:0] rho;
  logic signed [DATA_WIDTH-1:0] ux;
  logic signed [DATA_WIDTH-1:0] uy;
  logic                         dbz;
  logic                         ovf_x;
  logic                         ovf_y;

  // d2q9 velocities with direction 0 at rest
  int cx_ref [q_dirs] = '{0, 1, 0, -1, 0, 1, -1, -1, 1};
  int cy_ref [q_dirs] = '{0, 0, 1, 0, -1, 1, 1, -1, -1};

  logic signed [DATA_WIDTH-1:0] vals [q_dirs];
  logic signed [DATA_WIDTH-1:0] exp_rho;
  logic signed [DATA_WIDTH-1:0] exp_ux;
  logic signed [DATA_WIDTH-1:0] exp_uy;
  logic                         exp_dbz;
  logic                         exp_ovf_x;
  logic                         exp_ovf_y;

  int checks      = 0;
  int errors      = 0;
  int test_checks = 0;
  int test_errors = 0;
  int cycles      = 0;

  lbm_moments #(
    .DATA_WIDTH (DATA_WIDTH),
    .FRAC_BITS  (FRAC_BITS)
  ) i_dut (
    .clock_50 (clock_50),
    .arst_n   (arst_n),
    .req      (req),
    .fin      (fin),
    .ack      (ack),
    .rho      (rho),
    .ux       (ux),
    .uy       (uy),
    .dbz      (dbz),
    .ovf_x    (ovf_x),
    .ovf_y    (ovf_y)
  );

  always #20 clock_50 = ~clock_50;

  always @(posedge clock_50) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: DUT gave no result within %0d cycles", cycle_limit);
      $display("Checks failed");
      $finish;
    end
  end

  task automatic check_value(input string what, input longint got, input longint expected);
    checks++;
    if (got != expected) begin
      errors++;
      $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, got, expected);
    end
  endtask

  task automatic open_test();
    test_checks = checks;
    test_errors = errors;
  endtask

  task automatic close_test(input string name);
    $display("test %s: %0d checks, %0d errors", name, checks - test_checks,
             errors - test_errors);
  endtask

  // (mom << FRAC_BITS) / den truncated toward zero
  function automatic void divide_ref(input logic signed [DATA_WIDTH-1:0] mom,
                                     input logic signed [DATA_WIDTH-1:0] den,
                                     output logic signed [DATA_WIDTH-1:0] q,
                                     output logic zero,
                                     output logic over);
    longint num;
    longint quo;
    longint q_max;
    longint q_min;
    q_max = (longint'(1) <<< (DATA_WIDTH - 1)) - 1;
    q_min = -(longint'(1) <<< (DATA_WIDTH - 1));
    q     = '0;
    zero  = 1'b0;
    over  = 1'b0;
    if (den == 0) begin
      zero = 1'b1;
    end else begin
      num = longint'(mom) * (longint'(1) <<< FRAC_BITS);
      quo = num / longint'(den);
      if (quo > q_max || quo < q_min) begin
        over = 1'b1;
      end else begin
        q = quo[DATA_WIDTH-1:0];
      end
    end
  endfunction

  task automatic compute_expected();
    longint rho_w;
    longint px_w;
    longint py_w;
    logic   zero_y;
    rho_w = 0;
    px_w  = 0;
    py_w  = 0;
    for (int i = 0; i < q_dirs; i++) begin
      rho_w = rho_w + longint'(vals[i]);
      px_w  = px_w + cx_ref[i] * longint'(vals[i]);
      py_w  = py_w + cy_ref[i] * longint'(vals[i]);
    end
    // sums wrap to the datapath width
    exp_rho = rho_w[DATA_WIDTH-1:0];
    divide_ref(px_w[DATA_WIDTH-1:0], exp_rho, exp_ux, exp_dbz, exp_ovf_x);
    divide_ref(py_w[DATA_WIDTH-1:0], exp_rho, exp_uy, zero_y, exp_ovf_y);
  endtask

  // starts and ends on a falling edge with ack low
  task automatic run_cell(input int hold);
    logic signed [DATA_WIDTH-1:0] held_rho;
    logic signed [DATA_WIDTH-1:0] held_ux;
    logic signed [DATA_WIDTH-1:0] held_uy;
    compute_expected();
    for (int i = 0; i < q_dirs; i++) begin
      fin[i*DATA_WIDTH +: DATA_WIDTH] = vals[i];
    end
    req = 1'b1;
    @(negedge clock_50);
    while (!ack) begin
      @(negedge clock_50);
    end
    check_value("rho", rho, exp_rho);
    check_value("ux", ux, exp_ux);
    check_value("uy", uy, exp_uy);
    check_value("dbz", dbz, exp_dbz);
    check_value("ovf_x", ovf_x, exp_ovf_x);
    check_value("ovf_y", ovf_y, exp_ovf_y);
    held_rho = rho;
    held_ux  = ux;
    held_uy  = uy;
    repeat (hold) begin
      @(negedge clock_50);
      check_value("ack while req held", ack, 1);
      check_value("rho while req held", rho, held_rho);
      check_value("ux while req held", ux, held_ux);
      check_value("uy while req held", uy, held_uy);
      check_value("dbz while req held", dbz, exp_dbz);
      check_value("ovf_x while req held", ovf_x, exp_ovf_x);
      check_value("ovf_y while req held", ovf_y, exp_ovf_y);
    end
    req = 1'b0;
    @(negedge clock_50);
    check_value("ack after req low", ack, 0);
  endtask

  function automatic int unit_value();
    return $urandom % (unit_fp + 1);
  endfunction

  task automatic random_cell();
    for (int i = 0; i < q_dirs; i++) begin
      vals[i] = unit_value();
    end
    // keeps rho nonzero
    vals[0] = 1 + ($urandom % unit_fp);
  endtask

  task automatic clear_cell();
    for (int i = 0; i < q_dirs; i++) begin
      vals[i] = '0;
    end
  endtask

  initial begin
    int big;
    void'($urandom(32'hfdb6));
    arst_n = 1'b0;
    req    = 1'b0;
    fin    = '0;
    repeat (reset_cycles) @(negedge clock_50);
    arst_n = 1'b1;
    @(negedge clock_50);

    open_test();
    check_value("ack after reset", ack, 0);
    check_value("rho after reset", rho, 0);
    check_value("ux after reset", ux, 0);
    check_value("uy after reset", uy, 0);
    check_value("dbz after reset", dbz, 0);
    check_value("ovf_x after reset", ovf_x, 0);
    check_value("ovf_y after reset", ovf_y, 0);
    close_test("reset");

    open_test();
    for (int n = 0; n < n_random; n++) begin
      random_cell();
      run_cell(0);
    end
    close_test("random cells");

    open_test();
    for (int n = 0; n < n_symmetric; n++) begin
      clear_cell();
      vals[0] = 1 + ($urandom % unit_fp);
      run_cell(0);
      check_value("ux of rest cell", ux, 0);
      check_value("uy of rest cell", uy, 0);
    end
    for (int n = 0; n < n_symmetric; n++) begin
      vals[0] = 1 + ($urandom % unit_fp);
      // opposite directions carry equal values
      vals[1] = unit_value();
      vals[3] = vals[1];
      vals[2] = unit_value();
      vals[4] = vals[2];
      vals[5] = unit_value();
      vals[7] = vals[5];
      vals[6] = unit_value();
      vals[8] = vals[6];
      run_cell(0);
      check_value("ux of symmetric cell", ux, 0);
      check_value("uy of symmetric cell", uy, 0);
    end
    close_test("rest and symmetric cells");

    open_test();
    clear_cell();
    run_cell(0);
    check_value("dbz of zero cell", dbz, 1);
    check_value("ux of zero cell", ux, 0);
    check_value("uy of zero cell", uy, 0);
    close_test("zero cell");

    open_test();
    for (int n = 0; n < n_overflow; n++) begin
      clear_cell();
      vals[0] = 1 + ($urandom % 4);
      big = (1 << 26) + ($urandom % (1 << 26));
      // east and west cancel in rho but not in momentum
      vals[1] = (n % 2 == 0) ? big : -big;
      vals[3] = -vals[1];
      big = (1 << 26) + ($urandom % (1 << 26));
      vals[2] = big;
      vals[4] = -big;
      run_cell(0);
      check_value("ovf_x of tiny rho", ovf_x, 1);
      check_value("ovf_y of tiny rho", ovf_y, 1);
      check_value("ux of tiny rho", ux, 0);
      check_value("uy of tiny rho", uy, 0);
    end
    close_test("overflow");

    open_test();
    for (int n = 0; n < n_handshake; n++) begin
      random_cell();
      run_cell($urandom % (hold_max + 1));
    end
    close_test("handshake");

    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
logic/lbm_pkg.sv
logic/moment_sum.sv
logic/fp_divider.sv
logic/moment_ctrl.sv
logic/lbm_moments.sv
dv/lbm_moments_checker.sv
dv/lbm_moments_tb.sv

//--- run.sh
#!/bin/sh
# build and run the lbm_moments testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f \
  --top-module lbm_moments_tb -Mdir obj_dir -o sim_lbm_moments
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/sim_lbm_moments)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "All checks passed"; then
  exit 0
fi
exit 1
